//--- filelist.f
logic/eu_pkg.sv
logic/instruction_decoder.sv
logic/fetch_sequencer.sv
logic/effective_address.sv
logic/register_file.sv
logic/move_executor.sv
logic/execution_unit.sv
dv/clock_gen.sv
dv/execution_unit_tb.sv

//--- dv/execution_unit_tb.sv
module execution_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import eu_pkg::*;

    localparam int NUM_RANDOM = 400;
    localparam int NUM_DUMP = 8;
    localparam int MAX_CYCLES = (NUM_RANDOM + NUM_DUMP) * 40;

    logic      clk;
    logic      reset;
    byte_t     queue_data;
    logic      queue_valid;
    logic      queue_ready;
    seg_file_t seg_regs;
    bus_req_t  bus_req;
    logic      bus_req_valid;
    logic      bus_req_ready;
    word_t     bus_rdata;
    logic      bus_rvalid;
    logic      instruction_done;

    integer      seed;
    int          mismatches;
    int          errors;
    int          cycles;
    int          done_count;
    int          byte_idx;
    int          n_instr;
    byte_t       prog[$];
    bus_req_t    exp_reqs[$];
    // reference registers and byte-addressed memory
    word_t       model_regs[8];
    byte_t       model_mem[phys_addr_t];
    // memory seen by the bus model
    byte_t       bus_mem[phys_addr_t];
    logic        read_pending;
    int          read_wait;
    word_t       read_data_q;
    logic        last_stall;
    bus_req_t    last_req;
    logic [31:0] drive_rand;

    clock_gen clock0
    (
        .clk(clk),
        .reset(reset)
    );

    execution_unit dut0
    (
        .clk(clk),
        .reset(reset),
        .queue_data(queue_data),
        .queue_valid(queue_valid),
        .queue_ready(queue_ready),
        .seg_regs(seg_regs),
        .bus_req(bus_req),
        .bus_req_valid(bus_req_valid),
        .bus_req_ready(bus_req_ready),
        .bus_rdata(bus_rdata),
        .bus_rvalid(bus_rvalid),
        .instruction_done(instruction_done)
    );

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // initial memory contents mixing every address bit
    function automatic byte_t fill_byte(input phys_addr_t a);
        return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]} ^ 8'ha5;
    endfunction

    function automatic byte_t model_byte(input phys_addr_t a);
        return model_mem.exists(a) ? model_mem[a] : fill_byte(a);
    endfunction

    function automatic byte_t bus_byte(input phys_addr_t a);
        return bus_mem.exists(a) ? bus_mem[a] : fill_byte(a);
    endfunction

    // byte ids 4-7 are the high halves of aw cw dw bw
    function automatic word_t model_reg_read(input reg_id_t id, input logic w);
        word_t pair;
        pair = model_regs[{1'b0, id[1:0]}];
        if (w)
            return model_regs[id];
        return id[2] ? {8'h00, pair[15:8]} : {8'h00, pair[7:0]};
    endfunction

    function automatic void model_reg_write(input reg_id_t id, input logic w, input word_t d);
        if (w)
            model_regs[id] = d;
        else if (id[2])
            model_regs[{1'b0, id[1:0]}][15:8] = d[7:0];
        else
            model_regs[{1'b0, id[1:0]}][7:0] = d[7:0];
    endfunction

    // segment:offset address of a modrm memory operand
    function automatic phys_addr_t model_addr(input logic [1:0] mod, input logic [2:0] rm,
                                              input word_t disp);
        word_t off;
        word_t seg;
        logic  use_ss;
        use_ss = 1'b0;
        case (rm)
            3'd0: off = model_regs[3] + model_regs[6];
            3'd1: off = model_regs[3] + model_regs[7];
            3'd2:
            begin
                off = model_regs[5] + model_regs[6];
                use_ss = 1'b1;
            end
            3'd3:
            begin
                off = model_regs[5] + model_regs[7];
                use_ss = 1'b1;
            end
            3'd4: off = model_regs[6];
            3'd5: off = model_regs[7];
            3'd6:
            begin
                // mod 00 here is a bare direct address
                off = (mod == 2'b00) ? 16'h0000 : model_regs[5];
                use_ss = (mod != 2'b00);
            end
            default: off = model_regs[3];
        endcase
        if (mod == 2'b01)
            off = off + {{8{disp[7]}}, disp[7:0]};
        else if ((mod == 2'b10) || ((mod == 2'b00) && (rm == 3'b110)))
            off = off + disp;
        seg = use_ss ? seg_regs[47:32] : seg_regs[63:48];
        return {seg, 4'h0} + {4'h0, off};
    endfunction

    // form 0 is reg to r/m, 1 r/m to reg, 2 imm to reg and 3 imm to r/m
    task automatic emit_move(input int form, input logic w, input reg_id_t reg_f,
                             input logic [1:0] mod, input logic [2:0] rm,
                             input word_t disp, input word_t imm);
        logic       mem;
        logic       direct;
        phys_addr_t addr;
        phys_addr_t next_a;
        word_t      val;
        bus_req_t   req;
        mem = (form != 2) && (mod != 2'b11);
        direct = (mod == 2'b00) && (rm == 3'b110);
        addr = model_addr(mod, rm, disp);
        next_a = addr + 20'h1;
        case (form)
            0: prog.push_back(8'h88 | w);
            1: prog.push_back(8'h8a | w);
            2: prog.push_back(8'hb0 | {w, reg_f});
            default: prog.push_back(8'hc6 | w);
        endcase
        if (form != 2)
            prog.push_back({mod, reg_f, rm});
        if (mem && ((mod != 2'b00) || direct))
            prog.push_back(disp[7:0]);
        if (mem && ((mod == 2'b10) || direct))
            prog.push_back(disp[15:8]);
        if (form >= 2)
            prog.push_back(imm[7:0]);
        if ((form >= 2) && w)
            prog.push_back(imm[15:8]);

        // source value with byte operands zero-extended
        if (form == 0)
            val = model_reg_read(reg_f, w);
        else if (form == 1)
            val = mem ? {model_byte(next_a) & {8{w}}, model_byte(addr)} : model_reg_read(rm, w);
        else
            val = w ? imm : {8'h00, imm[7:0]};

        req.write = (form != 1);
        req.is_word = w;
        req.addr = addr;
        req.wdata = val;
        if (mem)
            exp_reqs.push_back(req);
        if (mem && (form != 1))
        begin
            model_mem[addr] = val[7:0];
            if (w)
                model_mem[next_a] = val[15:8];
        end
        else if ((form == 1) || (form == 2))
            model_reg_write(reg_f, w, val);
        else
            model_reg_write(rm, w, val);
        n_instr++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] r2;
        while (n_instr < NUM_RANDOM)
        begin
            r = rand32();
            r2 = rand32();
            // now and then an immediate load straight followed by a direct store
            if ((r[4:2] == 3'd0) && (n_instr < NUM_RANDOM - 1))
            begin
                emit_move(2, r[5], r[8:6], 2'b00, 3'b000, 16'h0000, r2[31:16]);
                emit_move(0, r[5], r[8:6], 2'b00, 3'b110, r2[15:0], 16'h0000);
            end
            else
                emit_move(int'(r[1:0]), r[5], r[8:6], r[10:9], r[13:11], r2[15:0], r2[31:16]);
        end
        // every register goes to its own direct word so both halves become visible
        for (int i = 0; i < NUM_DUMP; i++)
            emit_move(0, 1'b1, reg_id_t'(i), 2'b00, 3'b110, 16'h0040 + 16'(2 * i), 16'h0000);
    endtask

    // compare an accepted request and let the bus memory act on it
    task automatic check_request();
        bus_req_t   exp;
        phys_addr_t next_a;
        logic [31:0] rb;
        next_a = bus_req.addr + 20'h1;
        rb = rand32();
        assert (exp_reqs.size() != 0)
        else
        begin
            errors++;
            $display("unexpected bus request at cycle %0d", cycles);
        end
        if (exp_reqs.size() != 0)
        begin
            exp = exp_reqs.pop_front();
            assert (bus_req.write == exp.write)
            else
            begin
                mismatches++;
                $display("MISMATCH bus_req.write got %h expected %h", bus_req.write, exp.write);
            end
            assert (bus_req.is_word == exp.is_word)
            else
            begin
                mismatches++;
                $display("MISMATCH bus_req.is_word got %h expected %h",
                         bus_req.is_word, exp.is_word);
            end
            assert (bus_req.addr == exp.addr)
            else
            begin
                mismatches++;
                $display("MISMATCH bus_req.addr got %h expected %h", bus_req.addr, exp.addr);
            end
            // write data only means something on a write
            assert (!exp.write || (bus_req.wdata == exp.wdata))
            else
            begin
                mismatches++;
                $display("MISMATCH bus_req.wdata got %h expected %h", bus_req.wdata, exp.wdata);
            end
        end
        if (bus_req.write)
        begin
            bus_mem[bus_req.addr] = bus_req.wdata[7:0];
            if (bus_req.is_word)
                bus_mem[next_a] = bus_req.wdata[15:8];
        end
        else
        begin
            // byte reads carry junk in the high lane
            read_pending = 1'b1;
            read_wait = 1 + int'(rb[1:0]);
            read_data_q = bus_req.is_word ? {bus_byte(next_a), bus_byte(bus_req.addr)}
                                          : {rb[15:8], bus_byte(bus_req.addr)};
        end
    endtask

    // handshakes are counted on the rising edge
    always @(posedge clk)
    begin
        cycles++;
        if (!reset)
        begin
            if (queue_valid && queue_ready)
                byte_idx++;
            if (instruction_done)
                done_count++;
            if (bus_rvalid)
                read_pending = 1'b0;
            assert (!last_stall || (bus_req_valid && (bus_req == last_req)))
            else
            begin
                errors++;
                $display("bus request changed or dropped before ready at cycle %0d", cycles);
            end
            last_stall = bus_req_valid && !bus_req_ready;
            last_req = bus_req;
            if (bus_req_valid && bus_req_ready)
                check_request();
        end
    end

    // inputs change on the falling edge
    always @(negedge clk)
    begin
        // idle outputs through reset and the cycle after
        if ((cycles >= 1) && (cycles <= 4))
        begin
            assert (!bus_req_valid && !instruction_done && queue_ready)
            else
            begin
                errors++;
                $display("outputs not idle around reset at cycle %0d", cycles);
            end
        end
        drive_rand = rand32();
        queue_valid = (byte_idx < prog.size()) && (drive_rand[1:0] != 2'b00);
        queue_data = queue_valid ? prog[byte_idx] : drive_rand[15:8];
        bus_req_ready = drive_rand[2];
        bus_rvalid = 1'b0;
        if (read_pending)
        begin
            if (read_wait <= 1)
            begin
                bus_rvalid = 1'b1;
                bus_rdata = read_data_q;
            end
            else
                read_wait--;
        end
    end

    initial
    begin
        seed = 32'h7c52;
        queue_data = '0;
        queue_valid = 1'b0;
        bus_req_ready = 1'b0;
        bus_rdata = '0;
        bus_rvalid = 1'b0;
        mismatches = 0;
        errors = 0;
        cycles = 0;
        done_count = 0;
        byte_idx = 0;
        n_instr = 0;
        read_pending = 1'b0;
        read_wait = 0;
        last_stall = 1'b0;
        seg_regs = {rand32(), rand32()};
        for (int i = 0; i < 8; i++)
            model_regs[i] = '0;
        build_program();

        while ((done_count < n_instr) && (cycles < MAX_CYCLES))
            @(negedge clk);
        if (done_count < n_instr)
        begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d instructions done",
                     cycles, done_count, n_instr);
        end
        else
        begin
            // a few idle cycles to catch stray pulses or requests
            repeat (10)
                @(negedge clk);
            assert (done_count == n_instr)
            else
            begin
                mismatches++;
                $display("MISMATCH instruction_done count got %h expected %h",
                         done_count, n_instr);
            end
            assert ((exp_reqs.size() == 0) && (byte_idx == prog.size()))
            else
            begin
                errors++;
                $display("bus requests missing or queue bytes left over at the end");
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, errors);
        if ((mismatches + errors) == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- dv/clock_gen.sv
module clock_gen
(
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 3;

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    // reset held over three rising edges, released on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- logic/execution_unit.sv
module execution_unit
(
    input  logic              clk,
    input  logic              reset,
    input  eu_pkg::byte_t     queue_data,
    input  logic              queue_valid,
    output logic              queue_ready,
    input  eu_pkg::seg_file_t seg_regs,
    output eu_pkg::bus_req_t  bus_req,
    output logic              bus_req_valid,
    input  logic              bus_req_ready,
    input  eu_pkg::word_t     bus_rdata,
    input  logic              bus_rvalid,
    output logic              instruction_done
);
    import eu_pkg::*;

    // fetch to execute handoff
    instr_t     instr;
    logic       instr_valid;
    logic       instr_ready;

    // address path
    phys_addr_t phys_addr;
    reg_id_t    base_id;
    reg_id_t    index_id;
    word_t      base_val;
    word_t      index_val;

    // register file ports
    reg_id_t    read_id;
    logic       read_word;
    word_t      read_data;
    logic       we;
    reg_id_t    write_id;
    logic       write_word;
    word_t      write_data;

    fetch_sequencer fetch0
    (
        .clk(clk),
        .reset(reset),
        .queue_data(queue_data),
        .queue_valid(queue_valid),
        .queue_ready(queue_ready),
        .instr(instr),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready)
    );

    // address is formed from the instruction offered for handoff
    effective_address ea0
    (
        .modrm(instr.modrm),
        .disp(instr.disp),
        .disp_word(instr.info.disp_word),
        .seg_regs(seg_regs),
        .base_val(base_val),
        .index_val(index_val),
        .base_id(base_id),
        .index_id(index_id),
        .phys_addr(phys_addr)
    );

    register_file regs0
    (
        .clk(clk),
        .reset(reset),
        .we(we),
        .write_id(write_id),
        .write_word(write_word),
        .write_data(write_data),
        .read_id(read_id),
        .read_word(read_word),
        .read_data(read_data),
        .base_id(base_id),
        .index_id(index_id),
        .base_val(base_val),
        .index_val(index_val)
    );

    move_executor exec0
    (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .phys_addr(phys_addr),
        .read_id(read_id),
        .read_word(read_word),
        .read_data(read_data),
        .we(we),
        .write_id(write_id),
        .write_word(write_word),
        .write_data(write_data),
        .bus_req(bus_req),
        .bus_req_valid(bus_req_valid),
        .bus_req_ready(bus_req_ready),
        .bus_rdata(bus_rdata),
        .bus_rvalid(bus_rvalid),
        .instruction_done(instruction_done)
    );

endmodule

//--- logic/move_executor.sv
module move_executor
(
    input  logic               clk,
    input  logic               reset,
    input  eu_pkg::instr_t     instr,
    input  logic               instr_valid,
    output logic               instr_ready,
    input  eu_pkg::phys_addr_t phys_addr,
    output eu_pkg::reg_id_t    read_id,
    output logic               read_word,
    input  eu_pkg::word_t      read_data,
    output logic               we,
    output eu_pkg::reg_id_t    write_id,
    output logic               write_word,
    output eu_pkg::word_t      write_data,
    output eu_pkg::bus_req_t   bus_req,
    output logic               bus_req_valid,
    input  logic               bus_req_ready,
    input  eu_pkg::word_t      bus_rdata,
    input  logic               bus_rvalid,
    output logic               instruction_done
);
    import eu_pkg::*;

    exec_state_e state;
    instr_t      instr_q;
    phys_addr_t  addr_q;
    instr_t      cur;
    reg_id_t     rm_id;
    logic        mem_op;
    word_t       src_val;

    // in IDLE work on the instruction being offered, else on the held one
    assign cur = (state == IDLE) ? instr : instr_q;
    assign rm_id = cur.modrm[2:0];
    assign mem_op = (cur.info.src_kind == MEM) || (cur.info.dst_kind == MEM);

    assign instr_ready = (state == IDLE);

    // register operands, the one not named by reg_field is the rm register
    assign read_id = cur.info.reg_is_dst ? rm_id : cur.info.reg_field;
    assign write_id = cur.info.reg_is_dst ? cur.info.reg_field : rm_id;
    assign read_word = cur.info.is_word;
    assign write_word = cur.info.is_word;

    assign src_val = (cur.info.src_kind == IMM) ? cur.imm : read_data;
    assign write_data = (state == READ_WAIT) ? bus_rdata : src_val;

    // register-only moves write on the accepting edge, reads on the response
    assign we = ((state == IDLE) && instr_valid && !mem_op && (cur.info.dst_kind == REG))
             || ((state == READ_WAIT) && bus_rvalid);

    always_comb
    begin
        bus_req.write = (cur.info.dst_kind == MEM);
        bus_req.is_word = cur.info.is_word;
        bus_req.addr = addr_q;
        bus_req.wdata = src_val;
    end

    assign bus_req_valid = (state == BUS_REQ);
    assign instruction_done = (state == DONE);

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                    if (instr_valid)
                        state <= mem_op ? BUS_REQ : DONE;
                BUS_REQ:
                    // a write is finished once the bus takes it
                    if (bus_req_ready)
                        state <= bus_req.write ? DONE : READ_WAIT;
                READ_WAIT:
                    if (bus_rvalid)
                        state <= DONE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // address is taken while the registers it came from are current
    always_ff @(posedge clk)
    begin
        if (instr_ready && instr_valid)
        begin
            instr_q <= instr;
            addr_q <= phys_addr;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req));

    // the bus answers only an accepted read
    assert property (@(posedge clk) disable iff (reset)
        bus_rvalid |-> (state == READ_WAIT));

endmodule

//--- logic/register_file.sv
module register_file
(
    input  logic            clk,
    input  logic            reset,
    input  logic            we,
    input  eu_pkg::reg_id_t write_id,
    input  logic            write_word,
    input  eu_pkg::word_t   write_data,
    input  eu_pkg::reg_id_t read_id,
    input  logic            read_word,
    output eu_pkg::word_t   read_data,
    input  eu_pkg::reg_id_t base_id,
    input  eu_pkg::reg_id_t index_id,
    output eu_pkg::word_t   base_val,
    output eu_pkg::word_t   index_val
);
    import eu_pkg::*;

    word_t   regs [8];
    reg_id_t write_pair;
    reg_id_t read_pair;

    // byte ids map onto aw cw dw bw
    assign write_pair = {1'b0, write_id[1:0]};
    assign read_pair = {1'b0, read_id[1:0]};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            if (write_word)
                regs[write_id] <= write_data;
            // byte write touches one half only
            else if (write_id[2])
                regs[write_pair][15:8] <= write_data[7:0];
            else
                regs[write_pair][7:0] <= write_data[7:0];
        end
    end

    // byte reads come back zero-extended
    assign read_data = read_word ? regs[read_id]
                     : (read_id[2] ? {8'h00, regs[read_pair][15:8]}
                                   : {8'h00, regs[read_pair][7:0]});

    // address port, always full words
    assign base_val = regs[base_id];
    assign index_val = regs[index_id];

endmodule

//--- logic/effective_address.sv
module effective_address
(
    input  eu_pkg::byte_t      modrm,
    input  eu_pkg::word_t      disp,
    input  logic               disp_word,
    input  eu_pkg::seg_file_t  seg_regs,
    input  eu_pkg::word_t      base_val,
    input  eu_pkg::word_t      index_val,
    output eu_pkg::reg_id_t    base_id,
    output eu_pkg::reg_id_t    index_id,
    output eu_pkg::phys_addr_t phys_addr
);
    import eu_pkg::*;

    logic [1:0] mod;
    logic [2:0] rm;
    logic       direct;
    logic       use_base;
    logic       use_index;
    word_t      disp_ext;
    word_t      offset;
    seg_id_t    seg_id;
    word_t      seg_val;

    assign mod = modrm[7:6];
    assign rm = modrm[2:0];
    assign direct = (mod == 2'b00) && (rm == 3'b110);

    // rm 0-3 add base and index while 4-5 take the index and 6-7 the base alone
    // bp serves rm 010, 011 and 110, bw the rest
    assign base_id = (rm[1] && !(rm[2] && rm[0])) ? RID_BP : RID_BW;
    assign index_id = rm[0] ? RID_IY : RID_IX;
    assign use_base = !rm[2] || (rm[1] && !direct);
    assign use_index = !(rm[2] && rm[1]);

    // byte displacement is signed
    assign disp_ext = disp_word ? disp : {{8{disp[7]}}, disp[7:0]};

    // offset wraps at 16 bits
    // mod 00 carries no displacement unless direct
    assign offset = (use_base ? base_val : 16'h0000)
                  + (use_index ? index_val : 16'h0000)
                  + (((mod != 2'b00) || direct) ? disp_ext : 16'h0000);

    // bp-based modes go through ss
    assign seg_id = (use_base && (base_id == RID_BP)) ? SEG_SS : SEG_DS;
    assign seg_val = seg_regs[16 * seg_id +: 16];

    // segment times 16 plus offset wrapping at 1 MB
    assign phys_addr = {seg_val, 4'h0} + {4'h0, offset};

endmodule

//--- logic/fetch_sequencer.sv
module fetch_sequencer
(
    input  logic           clk,
    input  logic           reset,
    input  eu_pkg::byte_t  queue_data,
    input  logic           queue_valid,
    output logic           queue_ready,
    output eu_pkg::instr_t instr,
    output logic           instr_valid,
    input  logic           instr_ready
);
    import eu_pkg::*;

    fetch_state_e state;
    fetch_state_e next_state;
    byte_t        opcode_q;
    byte_t        modrm_q;
    word_t        disp_q;
    word_t        imm_q;
    byte_t        dec_opcode;
    byte_t        dec_modrm;
    decode_info_t info;

    // the decoder looks at the byte on the queue while it is being taken
    assign dec_opcode = (state == OPCODE) ? queue_data : opcode_q;
    assign dec_modrm = (state == MODRM) ? queue_data : modrm_q;

    instruction_decoder decoder0
    (
        .opcode(dec_opcode),
        .modrm(dec_modrm),
        .info(info)
    );

    always_comb
    begin
        case (state)
            OPCODE:
                next_state = info.need_modrm ? MODRM : (info.need_imm ? IMM_LOW : HOLD);
            MODRM:
                next_state = info.need_disp ? DISP_LOW : (info.need_imm ? IMM_LOW : HOLD);
            DISP_LOW:
                next_state = info.disp_word ? DISP_HIGH : (info.need_imm ? IMM_LOW : HOLD);
            DISP_HIGH:
                next_state = info.need_imm ? IMM_LOW : HOLD;
            IMM_LOW:
                next_state = info.imm_word ? IMM_HIGH : HOLD;
            IMM_HIGH:
                next_state = HOLD;
            default:
                next_state = instr_ready ? OPCODE : HOLD;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= OPCODE;
        else if ((state == HOLD) || queue_valid)
            state <= next_state;
    end

    // low bytes clear the high half so byte operands read zero-extended
    always_ff @(posedge clk)
    begin
        if (queue_valid && queue_ready)
        begin
            case (state)
                OPCODE:    opcode_q <= queue_data;
                MODRM:     modrm_q <= queue_data;
                DISP_LOW:  disp_q <= {8'h00, queue_data};
                DISP_HIGH: disp_q[15:8] <= queue_data;
                IMM_LOW:   imm_q <= {8'h00, queue_data};
                IMM_HIGH:  imm_q[15:8] <= queue_data;
                default:   ;
            endcase
        end
    end

    assign queue_ready = (state != HOLD);
    assign instr_valid = (state == HOLD);
    assign instr = '{opcode: opcode_q, modrm: modrm_q, disp: disp_q, imm: imm_q, info: info};

    // handoff payload held until the executor takes it
    assert property (@(posedge clk) disable iff (reset)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr));

endmodule

//--- logic/instruction_decoder.sv
module instruction_decoder
(
    input  eu_pkg::byte_t        opcode,
    input  eu_pkg::byte_t        modrm,
    output eu_pkg::decode_info_t info
);
    import eu_pkg::*;

    logic [1:0]    mod;
    logic [2:0]    rm;
    logic          direct;
    operand_kind_e rm_kind;

    assign mod = modrm[7:6];
    assign rm = modrm[2:0];

    // mod 00 with rm 110 carries a bare 16-bit address
    assign direct = (mod == 2'b00) && (rm == 3'b110);

    // mod 11 names a register, anything else is memory
    assign rm_kind = (mod == 2'b11) ? REG : MEM;

    always_comb
    begin
        // unknown opcode: one byte, nothing written
        info = '0;
        info.src_kind = IMM;
        info.dst_kind = IMM;
        info.is_word = opcode[0];
        info.reg_field = modrm[5:3];

        if (opcode[7:2] == 6'b100010)
        begin
            // 88/89 and 8a/8b, bit 1 is the direction
            info.need_modrm = 1'b1;
            info.reg_is_dst = opcode[1];
            if (opcode[1])
            begin
                info.src_kind = rm_kind;
                info.dst_kind = REG;
            end
            else
            begin
                info.src_kind = REG;
                info.dst_kind = rm_kind;
            end
        end
        else if (opcode[7:4] == 4'hb)
        begin
            // b0-bf, register and width sit in the opcode itself
            info.is_word = opcode[3];
            info.reg_field = opcode[2:0];
            info.reg_is_dst = 1'b1;
            info.need_imm = 1'b1;
            info.imm_word = opcode[3];
            info.src_kind = IMM;
            info.dst_kind = REG;
        end
        else if (opcode[7:1] == 7'b1100011)
        begin
            // c6/c7, reg field of modrm is ignored
            info.need_modrm = 1'b1;
            info.need_imm = 1'b1;
            info.imm_word = opcode[0];
            info.src_kind = IMM;
            info.dst_kind = rm_kind;
        end

        // displacement only follows a modrm that names memory
        if (info.need_modrm && (rm_kind == MEM))
        begin
            info.need_disp = (mod != 2'b00) || direct;
            info.disp_word = (mod == 2'b10) || direct;
        end
    end

endmodule

//--- logic/eu_pkg.sv
package eu_pkg;

    // plain widths of the 16-bit machine
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [19:0] phys_addr_t;

    // word ids: aw cw dw bw sp bp ix iy
    // byte ids: 0-3 low halves, 4-7 high halves of aw cw dw bw
    typedef logic [2:0]  reg_id_t;

    // es cs ss ds
    typedef logic [1:0]  seg_id_t;

    // segment n sits in bits [16*n +: 16]
    typedef logic [63:0] seg_file_t;

    // registers the address modes refer to
    localparam reg_id_t RID_BW = 3'd3;
    localparam reg_id_t RID_BP = 3'd5;
    localparam reg_id_t RID_IX = 3'd6;
    localparam reg_id_t RID_IY = 3'd7;

    localparam seg_id_t SEG_SS = 2'd2;
    localparam seg_id_t SEG_DS = 2'd3;

    // HOLD means a complete instruction is waiting for the executor
    typedef enum logic [2:0]
    {
        OPCODE    = 3'd0,
        MODRM     = 3'd1,
        DISP_LOW  = 3'd2,
        DISP_HIGH = 3'd3,
        IMM_LOW   = 3'd4,
        IMM_HIGH  = 3'd5,
        HOLD      = 3'd6
    } fetch_state_e;

    typedef enum logic [1:0]
    {
        IDLE      = 2'd0,
        BUS_REQ   = 2'd1,
        READ_WAIT = 2'd2,
        DONE      = 2'd3
    } exec_state_e;

    // an IMM destination marks an opcode with no effect
    typedef enum logic [1:0]
    {
        REG = 2'd0,
        MEM = 2'd1,
        IMM = 2'd2
    } operand_kind_e;

    typedef struct packed
    {
        logic          need_modrm;
        logic          need_disp;
        logic          disp_word;
        logic          need_imm;
        logic          imm_word;
        logic          is_word;
        // reg_field names the destination, the rm register the source
        logic          reg_is_dst;
        operand_kind_e src_kind;
        operand_kind_e dst_kind;
        reg_id_t       reg_field;
    } decode_info_t;

    typedef struct packed
    {
        byte_t        opcode;
        byte_t        modrm;
        word_t        disp;
        word_t        imm;
        decode_info_t info;
    } instr_t;

    typedef struct packed
    {
        logic       write;
        logic       is_word;
        phys_addr_t addr;
        word_t      wdata;
    } bus_req_t;

endpackage
